// ==== hdl/cu_pkg.sv ====
package cu_pkg;

  ////////////////////////////////////////
  // subsystem sizes
  ////////////////////////////////////////

  localparam int num_channels = 4;
  localparam int buffer_depth = 4;  // entries per buffer, also reset credit
  localparam int addr_width   = 64;
  localparam int size_width   = 12;
  localparam int tag_width    = 8;

  // channel select from address, 128-byte line interleave
  localparam int channel_lsb  = 7;
  localparam int channel_bits = $clog2(num_channels);

  // credit counters must hold buffer_depth itself
  localparam int credit_width = $clog2(buffer_depth + 1);
  localparam logic [credit_width-1:0] initial_credit = credit_width'(buffer_depth);

  typedef enum logic [2:0] {
    INVALID, READ_CL_NA, WRITE_NA, READ_CL_S, WRITE_MS
  } command_type;

  typedef struct packed {
    logic                  valid;
    command_type           command;
    logic [tag_width-1:0]  tag;
    logic [addr_width-1:0] address;
    logic [size_width-1:0] size;
  } command_line;

  // empty slot, shown on the output when nothing is granted
  localparam command_line idle_line = '{
    valid:   1'b0,
    command: INVALID,
    tag:     '0,
    address: '0,
    size:    '0
  };

endpackage

// ==== hdl/cmd_channel_if.sv ====
`timescale 1ns/1ps

// one command line plus its strobes
// push side: distributor -> buffer, ready is the credit return
// head side: buffer -> arbiter, ready is the pop grant
interface cmd_channel_if;

  logic                valid;    // push strobe, one cycle
  cu_pkg::command_line line;
  logic                request;  // buffer non-empty
  logic                ready;

  ////////////////////////////////////////
  // distributor to buffer
  ////////////////////////////////////////

  modport push_source (output valid, output line, input ready);
  modport push_sink (input valid, input line, output ready);

  ////////////////////////////////////////
  // buffer to arbiter
  ////////////////////////////////////////

  modport head_source (output request, output line, input ready);
  modport head_sink (input request, input line, output ready);

endinterface

// ==== hdl/command_distributor.sv ====
`timescale 1ns/1ps

module command_distributor (
  input  logic                clock,
  input  logic                rstn,
  input  logic                cmd_valid,
  input  cu_pkg::command_line cmd_in,
  output logic                cmd_dropped,
  cmd_channel_if.push_source  channels [cu_pkg::num_channels]
);

  logic [cu_pkg::channel_bits-1:0] channel_sel;
  logic [cu_pkg::credit_width-1:0] credits [cu_pkg::num_channels];
  logic                            has_credit;

  // line interleave on address bits 8:7
  assign channel_sel = cmd_in.address[cu_pkg::channel_lsb +: cu_pkg::channel_bits];
  assign has_credit  = (credits[channel_sel] != '0);

  ////////////////////////////////////////
  // per-channel push and credit count
  ////////////////////////////////////////

  for (genvar g = 0; g < cu_pkg::num_channels; g++) begin : g_channel
    logic push;
    logic credit_return;

    assign push          = cmd_valid && has_credit && (channel_sel == g);
    assign credit_return = channels[g].ready;  // buffer popped this cycle

    assign channels[g].valid = push;
    assign channels[g].line  = cmd_in;

    // returned credit is usable from the next cycle on
    always_ff @(posedge clock or negedge rstn) begin
      if (!rstn) begin
        credits[g] <= cu_pkg::initial_credit;
      end else begin
        case ({push, credit_return})
          2'b10:   credits[g] <= credits[g] - 1'b1;
          2'b01:   credits[g] <= credits[g] + 1'b1;
          default: credits[g] <= credits[g];  // both or neither
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // drop report
  ////////////////////////////////////////

  // target buffer full, command is lost and flagged a cycle later
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd_dropped <= 1'b0;
    end else begin
      cmd_dropped <= cmd_valid && !has_credit;
    end
  end

endmodule

// ==== hdl/command_buffer.sv ====
`timescale 1ns/1ps

module command_buffer #(
  parameter int depth = cu_pkg::buffer_depth
) (
  input  logic               clock,
  input  logic               rstn,
  cmd_channel_if.push_sink   push,
  cmd_channel_if.head_source head
);

  cu_pkg::command_line        entries [depth];
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth+1)-1:0] count;
  logic                       pop;

  // wrap at depth, so depth need not be a power of two
  function automatic logic [$clog2(depth)-1:0] next_ptr(
    input logic [$clog2(depth)-1:0] ptr
  );
    if (int'(ptr) == depth - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // head and credit return
  ////////////////////////////////////////

  assign head.request = (count != '0);
  assign head.line    = entries[rd_ptr];
  assign pop          = head.request && head.ready;
  assign push.ready   = pop;  // one credit back per pop

  ////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////

  // the distributor only pushes with credit, so never while full
  always_ff @(posedge clock) begin
    if (push.valid) begin
      entries[wr_ptr] <= push.line;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push.valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  // occupancy, push and pop may share a cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      count <= '0;
    end else begin
      case ({push.valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hdl/command_buffer_arbiter.sv ====
`timescale 1ns/1ps

module command_buffer_arbiter #(
  parameter int num_requests = cu_pkg::num_channels
) (
  input  logic                clock,
  input  logic                rstn,
  input  logic                enabled,
  cmd_channel_if.head_sink    requesters [num_requests],
  output cu_pkg::command_line command_arbiter_out
);

  logic [num_requests-1:0] requests;
  logic [num_requests-1:0] grant;
  cu_pkg::command_line     head_lines [num_requests];
  cu_pkg::command_line     selected;

  ////////////////////////////////////////
  // requester side
  ////////////////////////////////////////

  for (genvar g = 0; g < num_requests; g++) begin : g_request
    assign requests[g]         = requesters[g].request;
    assign head_lines[g]       = requesters[g].line;
    assign requesters[g].ready = grant[g] && enabled;  // pop only when enabled
  end

  // fixed priority, index 0 highest
  always_comb begin
    logic found;
    found = 1'b0;
    grant = '0;
    for (int i = 0; i < num_requests; i++) begin
      if (requests[i] && !found) begin
        grant[i] = 1'b1;
        found    = 1'b1;
      end
    end
  end

  // winner's line, idle when nobody asks
  always_comb begin
    selected = cu_pkg::idle_line;
    for (int i = 0; i < num_requests; i++) begin
      if (grant[i]) begin
        selected = head_lines[i];
      end
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_arbiter_out <= cu_pkg::idle_line;
    end else if (enabled) begin
      command_arbiter_out <= selected;
    end else begin
      command_arbiter_out <= cu_pkg::idle_line;  // disabled, nothing granted
    end
  end

endmodule

// ==== hdl/command_unit_top.sv ====
`timescale 1ns/1ps

module command_unit_top (
  input  logic                          clock,
  input  logic                          rstn,
  input  logic                          enabled,
  // command input, one per cycle
  input  logic                          cmd_valid,
  input  cu_pkg::command_type           cmd_command,
  input  logic [cu_pkg::tag_width-1:0]  cmd_tag,
  input  logic [cu_pkg::addr_width-1:0] cmd_address,
  input  logic [cu_pkg::size_width-1:0] cmd_size,
  output logic                          cmd_dropped,
  // arbitrated output
  output logic                          out_valid,
  output cu_pkg::command_type           out_command,
  output logic [cu_pkg::tag_width-1:0]  out_tag,
  output logic [cu_pkg::addr_width-1:0] out_address,
  output logic [cu_pkg::size_width-1:0] out_size
);

  cu_pkg::command_line cmd_in;
  cu_pkg::command_line arb_out;

  cmd_channel_if push_ch [cu_pkg::num_channels] ();  // distributor to buffers
  cmd_channel_if head_ch [cu_pkg::num_channels] ();  // buffers to arbiter

  assign cmd_in = '{
    valid:   cmd_valid,
    command: cmd_command,
    tag:     cmd_tag,
    address: cmd_address,
    size:    cmd_size
  };

  ////////////////////////////////////////
  // distributor
  ////////////////////////////////////////

  command_distributor distributor (
    .clock       (clock),
    .rstn        (rstn),
    .cmd_valid   (cmd_valid),
    .cmd_in      (cmd_in),
    .cmd_dropped (cmd_dropped),
    .channels    (push_ch)
  );

  // one buffer per channel
  for (genvar g = 0; g < cu_pkg::num_channels; g++) begin : g_buffer
    command_buffer #(
      .depth (cu_pkg::buffer_depth)
    ) buffer (
      .clock (clock),
      .rstn  (rstn),
      .push  (push_ch[g]),
      .head  (head_ch[g])
    );
  end

  ////////////////////////////////////////
  // arbiter and output fields
  ////////////////////////////////////////

  command_buffer_arbiter #(
    .num_requests (cu_pkg::num_channels)
  ) arbiter (
    .clock               (clock),
    .rstn                (rstn),
    .enabled             (enabled),
    .requesters          (head_ch),
    .command_arbiter_out (arb_out)
  );

  assign out_valid   = arb_out.valid;
  assign out_command = arb_out.command;
  assign out_tag     = arb_out.tag;
  assign out_address = arb_out.address;
  assign out_size    = arb_out.size;

endmodule

// ==== testbench/command_model.svh ====
////////////////////////////////////////
// reference model, one step per cycle
////////////////////////////////////////

typedef struct packed {
  cu_pkg::command_line line;
  int unsigned         push_cycle;
} queued_command;

queued_command       pending [cu_pkg::num_channels][$];  // per-channel queues
int                  credit_count [cu_pkg::num_channels];
cu_pkg::command_line expected_out;   // output predicted for the next cycle
logic                expected_drop;  // drop strobe predicted for the next cycle
int unsigned         model_cycle;
int                  accepted_count;
int                  dropped_count;
int                  delivered_count;

function automatic void reset_model();
  for (int i = 0; i < cu_pkg::num_channels; i++) begin
    pending[i].delete();
    credit_count[i] = cu_pkg::buffer_depth;
  end
  expected_out    = '0;
  expected_drop   = 1'b0;
  model_cycle     = 0;
  accepted_count  = 0;
  dropped_count   = 0;
  delivered_count = 0;
endfunction

// line interleave, address bits 8:7
function automatic int channel_of(input logic [cu_pkg::addr_width-1:0] address);
  return int'(address[8:7]);
endfunction

// one cycle of the command path, predicting the outputs of the next cycle
function automatic void step_model(
  input logic                valid,
  input cu_pkg::command_line line,
  input logic                en
);
  int            winner;
  int            return_ch;
  int            ch;
  queued_command entry;
  winner    = -1;
  return_ch = -1;
  // a command is visible to the arbiter from the cycle after its push
  for (int i = 0; i < cu_pkg::num_channels; i++) begin
    if (winner < 0 && pending[i].size() > 0 && pending[i][0].push_cycle < model_cycle) begin
      winner = i;
    end
  end
  expected_out = '0;
  if (en && winner >= 0) begin
    entry        = pending[winner].pop_front();
    expected_out = entry.line;
    return_ch    = winner;
    delivered_count++;
  end
  // credit seen here is the one before this cycle's return
  expected_drop = 1'b0;
  if (valid) begin
    ch = channel_of(line.address);
    if (credit_count[ch] > 0) begin
      credit_count[ch]--;
      entry.line       = line;
      entry.push_cycle = model_cycle;
      pending[ch].push_back(entry);
      accepted_count++;
    end else begin
      expected_drop = 1'b1;
      dropped_count++;
    end
  end
  if (return_ch >= 0) begin
    credit_count[return_ch]++;  // usable next cycle
  end
  model_cycle++;
endfunction

// commands still queued or waiting to show on the output
function automatic int outstanding_commands();
  int total;
  total = int'(expected_out.valid);
  for (int i = 0; i < cu_pkg::num_channels; i++) begin
    total += pending[i].size();
  end
  return total;
endfunction

// ==== testbench/tb_command_unit.sv ====
`timescale 1ns/1ps

module tb_command_unit;

  localparam int drain_timeout = 200;

  logic                          clock;
  logic                          rstn;
  logic                          enabled;
  logic                          cmd_valid;
  cu_pkg::command_type           cmd_command;
  logic [cu_pkg::tag_width-1:0]  cmd_tag;
  logic [cu_pkg::addr_width-1:0] cmd_address;
  logic [cu_pkg::size_width-1:0] cmd_size;
  logic                          cmd_dropped;
  logic                          out_valid;
  cu_pkg::command_type           out_command;
  logic [cu_pkg::tag_width-1:0]  out_tag;
  logic [cu_pkg::addr_width-1:0] out_address;
  logic [cu_pkg::size_width-1:0] out_size;

  integer seed;
  int     disable_left;  // cycles left in a disabled burst

  command_unit_top uut (
    .clock       (clock),
    .rstn        (rstn),
    .enabled     (enabled),
    .cmd_valid   (cmd_valid),
    .cmd_command (cmd_command),
    .cmd_tag     (cmd_tag),
    .cmd_address (cmd_address),
    .cmd_size    (cmd_size),
    .cmd_dropped (cmd_dropped),
    .out_valid   (out_valid),
    .out_command (out_command),
    .out_tag     (out_tag),
    .out_address (out_address),
    .out_size    (out_size)
  );

  `include "command_model.svh"

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;  // 4 ns period
  end

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  ////////////////////////////////////////
  // output checks
  ////////////////////////////////////////

  task automatic check_outputs();
    assert (cmd_dropped === expected_drop) else begin
      $display("Mismatch at %0t: cmd_dropped expected %0b actual %0b",
               $time, expected_drop, cmd_dropped);
      stop_on_error();
    end
    assert (out_valid === expected_out.valid) else begin
      $display("Mismatch at %0t: out_valid expected %0b actual %0b",
               $time, expected_out.valid, out_valid);
      stop_on_error();
    end
    if (expected_out.valid) begin
      assert (out_command === expected_out.command) else begin
        $display("Mismatch at %0t: out_command expected %0d actual %0d",
                 $time, expected_out.command, out_command);
        stop_on_error();
      end
      assert (out_tag === expected_out.tag) else begin
        $display("Mismatch at %0t: out_tag expected %h actual %h",
                 $time, expected_out.tag, out_tag);
        stop_on_error();
      end
      assert (out_address === expected_out.address) else begin
        $display("Mismatch at %0t: out_address expected %h actual %h",
                 $time, expected_out.address, out_address);
        stop_on_error();
      end
      assert (out_size === expected_out.size) else begin
        $display("Mismatch at %0t: out_size expected %h actual %h",
                 $time, expected_out.size, out_size);
        stop_on_error();
      end
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // check last edge, drive this cycle, then advance the model
  task automatic run_cycle(input logic valid, input cu_pkg::command_line line, input logic en);
    @(posedge clock);
    #1;
    check_outputs();
    cmd_valid   = valid;
    cmd_command = line.command;
    cmd_tag     = line.tag;
    cmd_address = line.address;
    cmd_size    = line.size;
    enabled     = en;
    step_model(valid, line, en);
  endtask

  // channel < 0 leaves the address fully random
  function automatic cu_pkg::command_line random_line(input int channel);
    cu_pkg::command_line line;
    line.valid   = 1'b1;
    line.command = cu_pkg::command_type'($unsigned($random(seed)) % 5);
    line.tag     = cu_pkg::tag_width'($random(seed));
    line.address = {$random(seed), $random(seed)};
    line.size    = cu_pkg::size_width'($random(seed));
    if (channel >= 0) begin
      line.address[8:7] = 2'(channel);
    end
    return line;
  endfunction

  function automatic logic next_enable();
    if (disable_left > 0) begin
      disable_left--;
      return 1'b0;
    end
    if ($unsigned($random(seed)) % 20 == 0) begin
      disable_left = $unsigned($random(seed)) % 8;  // burst of 1 to 8 cycles
      return 1'b0;
    end
    return 1'b1;
  endfunction

  initial begin
    cu_pkg::command_line line;
    logic                valid;
    logic                en;
    int                  density;
    int                  waited;
    seed         = 32'hf628;
    disable_left = 0;
    rstn         = 1'b0;
    enabled      = 1'b0;
    cmd_valid    = 1'b0;
    cmd_command  = cu_pkg::INVALID;
    cmd_tag      = '0;
    cmd_address  = '0;
    cmd_size     = '0;
    reset_model();
    repeat (3) @(posedge clock);
    #1 rstn = 1'b1;

    repeat (6) run_cycle(1'b0, '0, 1'b1);  // quiet after reset

    // mixed traffic with density changing every 50 cycles
    density = 0;
    for (int i = 0; i < 800; i++) begin
      if (i % 50 == 0) begin
        density = $unsigned($random(seed)) % 256;
      end
      valid = ($unsigned($random(seed)) % 256) < density;
      line  = random_line(-1);
      en    = next_enable();
      run_cycle(valid, line, en);
    end

    ////////////////////////////////////////
    // long stream into channel 2
    ////////////////////////////////////////
    for (int i = 0; i < 300; i++) begin
      valid = ($unsigned($random(seed)) % 16) != 0;
      line  = random_line(2);
      en    = next_enable();
      run_cycle(valid, line, en);
    end

    waited = 0;
    while (outstanding_commands() != 0) begin
      if (waited == drain_timeout) begin
        $display("drain timeout: %0d commands still missing", outstanding_commands());
        stop_on_error();
      end
      run_cycle(1'b0, '0, 1'b1);
      waited++;
    end

    // nothing more may come out once drained
    repeat (4) run_cycle(1'b0, '0, 1'b1);

    assert (dropped_count > 0) else begin
      $display("no command was ever dropped, the full buffer case was never reached");
      stop_on_error();
    end
    $display("accepted %0d, dropped %0d, delivered %0d",
             accepted_count, dropped_count, delivered_count);
    $display("sim passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+testbench
hdl/cu_pkg.sv
hdl/cmd_channel_if.sv
hdl/command_distributor.sv
hdl/command_buffer.sv
hdl/command_buffer_arbiter.sv
hdl/command_unit_top.sv
testbench/tb_command_unit.sv

// ==== Bender.yml ====
package:
  name: command_unit

sources:
  - hdl/cu_pkg.sv
  - hdl/cmd_channel_if.sv
  - hdl/command_distributor.sv
  - hdl/command_buffer.sv
  - hdl/command_buffer_arbiter.sv
  - hdl/command_unit_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_command_unit.sv
